// File: common/gat_pkg.sv
package gat_pkg;

  localparam int unsigned NUM_PE     = 16;
  localparam int unsigned PE_W       = 12;
  localparam int unsigned LANE_IDX_W = $clog2(NUM_PE);
  localparam int unsigned SHIFT_W    = 2;

  // Sparse entry layout is {row_end, lane, shift, value}
  localparam int unsigned ENTRY_W         = 1 + LANE_IDX_W + SHIFT_W + PE_W;
  localparam int unsigned ENT_VALUE_LSB   = 0;
  localparam int unsigned ENT_SHIFT_LSB   = PE_W;
  localparam int unsigned ENT_LANE_LSB    = PE_W + SHIFT_W;
  localparam int unsigned ENT_ROW_END_BIT = ENTRY_W - 1;

  localparam int unsigned ENTRY_AW        = 18;
  localparam int unsigned ENTRY_DEPTH     = 1 << ENTRY_AW;
  localparam int unsigned ROW_W           = 14;
  localparam int unsigned FEAT_AW         = 16;
  localparam int unsigned FEAT_DW         = 32;
  localparam int unsigned FEAT_HALF_W     = FEAT_DW / 2;
  localparam int unsigned WORDS_PER_ROW   = NUM_PE / 2;
  localparam int unsigned WORD_IDX_W      = $clog2(WORDS_PER_ROW);
  localparam int unsigned FEAT_ADDR_LIMIT = 43328;

  localparam int unsigned CAPTURE_LANE  = 2;
  localparam int unsigned CAPTURE_ROW_A = 10;
  localparam int unsigned CAPTURE_ROW_B = 20;

  localparam int unsigned DMVM_LAT = 4;
  localparam int unsigned SM_LAT   = 3;
  localparam int unsigned AGGR_LAT = 5;
  localparam int unsigned TIMER_W  = 8;

  localparam int unsigned DBG_W          = 32;
  localparam int unsigned NUM_FLAGS      = 10;
  localparam int unsigned FLAG_FEAT_WR   = 9;
  localparam int unsigned FLAG_ADDR_OVER = 8;
  localparam int unsigned FLAG_SPMM_VLD  = 7;
  localparam int unsigned FLAG_SPMM_RDY  = 6;
  localparam int unsigned FLAG_DMVM_VLD  = 5;
  localparam int unsigned FLAG_DMVM_RDY  = 4;
  localparam int unsigned FLAG_SM_VLD    = 3;
  localparam int unsigned FLAG_SM_RDY    = 2;
  localparam int unsigned FLAG_AGGR_VLD  = 1;
  localparam int unsigned FLAG_AGGR_RDY  = 0;

  typedef logic [PE_W-1:0]      pe_data_t;
  typedef logic [ENTRY_W-1:0]   entry_t;
  typedef logic [ENTRY_AW-1:0]  entry_addr_t;
  typedef logic [ROW_W-1:0]     row_addr_t;
  typedef logic [FEAT_AW-1:0]   feat_addr_t;
  typedef logic [FEAT_DW-1:0]   feat_data_t;
  typedef logic [NUM_FLAGS-1:0] dbg_flags_t;

  typedef enum logic [2:0] {
    IDLE,
    SPMM_RUN,
    DMVM_RUN,
    SM_RUN,
    AGGR_RUN
  } seq_state_t;

endpackage

// File: debugger/debugger.sv
module debugger (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     clear_i,
  input  logic                     spmm_vld_i,
  input  logic                     spmm_rdy_i,
  input  logic                     dmvm_vld_i,
  input  logic                     dmvm_rdy_i,
  input  logic                     sm_vld_i,
  input  logic                     sm_rdy_i,
  input  logic                     aggr_vld_i,
  input  logic                     aggr_rdy_i,
  input  logic                     row_vld_i,
  input  gat_pkg::row_addr_t       wh_bram_addra_i,
  input  gat_pkg::pe_data_t        sppe2_i,
  input  logic                     feat_bram_ena_i,
  input  gat_pkg::feat_addr_t      feat_bram_addra_i,
  output logic [gat_pkg::DBG_W-1:0] debug_1_o,
  output logic [gat_pkg::DBG_W-1:0] debug_2_o,
  output logic [gat_pkg::DBG_W-1:0] debug_3_o
);

  gat_pkg::dbg_flags_t              flags_q;
  gat_pkg::dbg_flags_t              flags_set;
  logic [gat_pkg::DBG_W-1:0]        sm_cnt_q;
  gat_pkg::pe_data_t                cap_a_q;
  gat_pkg::pe_data_t                cap_b_q;

  always_comb begin
    flags_set                          = '0;
    flags_set[gat_pkg::FLAG_FEAT_WR]   = feat_bram_ena_i;
    flags_set[gat_pkg::FLAG_ADDR_OVER] = feat_bram_ena_i &&
        (feat_bram_addra_i >= gat_pkg::feat_addr_t'(gat_pkg::FEAT_ADDR_LIMIT));
    flags_set[gat_pkg::FLAG_SPMM_VLD]  = spmm_vld_i;
    flags_set[gat_pkg::FLAG_SPMM_RDY]  = spmm_rdy_i;
    flags_set[gat_pkg::FLAG_DMVM_VLD]  = dmvm_vld_i;
    flags_set[gat_pkg::FLAG_DMVM_RDY]  = dmvm_rdy_i;
    flags_set[gat_pkg::FLAG_SM_VLD]    = sm_vld_i;
    flags_set[gat_pkg::FLAG_SM_RDY]    = sm_rdy_i;
    flags_set[gat_pkg::FLAG_AGGR_VLD]  = aggr_vld_i;
    flags_set[gat_pkg::FLAG_AGGR_RDY]  = aggr_rdy_i;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_q  <= '0;
      sm_cnt_q <= '0;
      cap_a_q  <= '0;
      cap_b_q  <= '0;
    end else if (clear_i) begin
      flags_q  <= '0;
      sm_cnt_q <= '0;
      cap_a_q  <= '0;
      cap_b_q  <= '0;
    end else begin
      flags_q <= flags_q | flags_set;  // Bits stay set until cleared
      if (sm_vld_i) begin
        sm_cnt_q <= sm_cnt_q + 1'b1;
      end
      if (row_vld_i && wh_bram_addra_i == gat_pkg::row_addr_t'(gat_pkg::CAPTURE_ROW_A)) begin
        cap_a_q <= sppe2_i;
      end
      if (row_vld_i && wh_bram_addra_i == gat_pkg::row_addr_t'(gat_pkg::CAPTURE_ROW_B)) begin
        cap_b_q <= sppe2_i;
      end
    end
  end

  assign debug_1_o = sm_cnt_q;
  assign debug_2_o = gat_pkg::DBG_W'(flags_q);
  assign debug_3_o = {{(gat_pkg::FEAT_HALF_W - gat_pkg::PE_W){1'b0}}, cap_b_q,
                      {(gat_pkg::FEAT_HALF_W - gat_pkg::PE_W){1'b0}}, cap_a_q};

endmodule

// File: dv/tb_gat_top.sv
module tb_gat_top;

  localparam int MAX_ROWS     = 32;
  localparam int MAX_ENTS     = 64;
  localparam int DONE_TIMEOUT = 3000;
  localparam int OVER_BIT     = 8;   // Over-limit flag, second from the top of ten

  logic                 clk;
  logic                 rst_n;
  logic                 load_we;
  gat_pkg::entry_addr_t load_addr;
  gat_pkg::entry_t      load_data;
  logic                 start;
  gat_pkg::entry_addr_t nnz;
  gat_pkg::feat_addr_t  feat_base;
  logic                 dbg_clear;
  logic                 done;
  logic                 feat_ena;
  gat_pkg::feat_addr_t  feat_addr;
  gat_pkg::feat_data_t  feat_din;
  logic [31:0]          debug_1;
  logic [31:0]          debug_2;
  logic [31:0]          debug_3;

  gat_pkg::entry_t     ents [0:MAX_ENTS-1];
  logic [11:0]         exp_lane [0:MAX_ROWS-1][0:15];
  int                  num_ents;
  int                  num_rows;
  logic [31:0]         rng_state;
  int                  errors;
  int                  tests_run;
  gat_pkg::feat_addr_t wr_addr_q [$];
  gat_pkg::feat_data_t wr_data_q [$];

  gat_top dut_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .load_we_i         (load_we),
    .load_addr_i       (load_addr),
    .load_data_i       (load_data),
    .start_i           (start),
    .nnz_i             (nnz),
    .feat_base_i       (feat_base),
    .dbg_clear_i       (dbg_clear),
    .done_o            (done),
    .feat_bram_ena_o   (feat_ena),
    .feat_bram_addra_o (feat_addr),
    .feat_bram_din_o   (feat_din),
    .debug_1_o         (debug_1),
    .debug_2_o         (debug_2),
    .debug_3_o         (debug_3)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Every feature write is recorded in order
  always @(negedge clk) begin
    if (feat_ena === 1'b1) begin
      wr_addr_q.push_back(feat_addr);
      wr_data_q.push_back(feat_din);
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic gat_pkg::entry_t make_entry(input logic row_end, input logic [3:0] lane,
                                                 input logic [1:0] shift,
                                                 input logic [11:0] value);
    return {row_end, lane, shift, value};
  endfunction

  // Word k holds lane 2k+1 at bits 27:16 and lane 2k at bits 11:0
  function automatic logic [31:0] pack_word(input int row, input int k);
    return {4'h0, exp_lane[row][2*k+1], 4'h0, exp_lane[row][2*k]};
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    $display("Mismatch at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, expected);
    errors++;
  endtask

  task automatic build_random(input int rows, input int per_row);
    logic [31:0] r;
    num_ents = rows * per_row;
    for (int i = 0; i < num_ents; i++) begin
      r       = next_rand();
      ents[i] = make_entry((i % per_row) == per_row - 1, r[3:0], r[5:4], r[17:6]);
    end
  endtask

  // Lanes accumulate value * 2^shift modulo 4096 and are stored at each row end
  task automatic compute_model();
    int acc [0:15];
    int lane;
    int sum;
    num_rows = 0;
    for (int l = 0; l < 16; l++) acc[l] = 0;
    for (int i = 0; i < num_ents; i++) begin
      lane      = ents[i][17:14];
      sum       = acc[lane] + int'(ents[i][11:0]) * (2 ** int'(ents[i][13:12]));
      acc[lane] = sum % 4096;
      if (ents[i][18]) begin
        for (int l = 0; l < 16; l++) begin
          exp_lane[num_rows][l] = acc[l][11:0];
          acc[l]                = 0;
        end
        num_rows++;
      end
    end
  endtask

  task automatic load_entries();
    for (int i = 0; i < num_ents; i++) begin
      @(negedge clk);
      load_we   = 1'b1;
      load_addr = gat_pkg::entry_addr_t'(i);
      load_data = ents[i];
    end
    @(negedge clk);
    load_we = 1'b0;
  endtask

  task automatic run_pass(input int base);
    int cycles;
    wr_addr_q.delete();
    wr_data_q.delete();
    @(negedge clk);
    start     = 1'b1;
    nnz       = gat_pkg::entry_addr_t'(num_ents);
    feat_base = gat_pkg::feat_addr_t'(base);
    @(negedge clk);
    start  = 1'b0;
    cycles = 0;
    while (done !== 1'b1 && cycles < DONE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (done !== 1'b1) begin
      $display("Timeout at %0t: done_o never rose within %0d cycles", $time, DONE_TIMEOUT);
      errors++;
    end
  endtask

  task automatic check_writes(input int base);
    int idx;
    if (wr_addr_q.size() != num_rows * 8) begin
      $display("Error at %0t: expected %0d feature writes but saw %0d", $time,
               num_rows * 8, wr_addr_q.size());
      errors++;
    end else begin
      for (int r = 0; r < num_rows; r++) begin
        for (int k = 0; k < 8; k++) begin
          idx = r * 8 + k;
          if (wr_addr_q[idx] !== gat_pkg::feat_addr_t'(base + idx))
            report_mismatch("feat_bram_addra_o", wr_addr_q[idx], base + idx);
          if (wr_data_q[idx] !== pack_word(r, k))
            report_mismatch("feat_bram_din_o", wr_data_q[idx], pack_word(r, k));
        end
      end
    end
  endtask

  task automatic pulse_clear();
    @(negedge clk);
    dbg_clear = 1'b1;
    @(negedge clk);
    dbg_clear = 1'b0;
  endtask

  task automatic test_reset_state();
    tests_run++;
    for (int c = 0; c < 20; c++) begin
      @(negedge clk);
      if (done !== 1'b0) report_mismatch("done_o", done, 0);
      if (feat_ena !== 1'b0) report_mismatch("feat_bram_ena_o", feat_ena, 0);
      if (debug_1 !== 32'h0) report_mismatch("debug_1_o", debug_1, 0);
      if (debug_2 !== 32'h0) report_mismatch("debug_2_o", debug_2, 0);
      if (debug_3 !== 32'h0) report_mismatch("debug_3_o", debug_3, 0);
    end
  endtask

  task automatic test_single_pass();
    tests_run++;
    build_random(10, 3);
    compute_model();
    load_entries();
    run_pass(0);
    check_writes(0);
  endtask

  task automatic test_flags_counter();
    logic [31:0] exp_flags;
    tests_run++;
    exp_flags = 32'h0000_03ff & ~(32'h1 << OVER_BIT);
    if (debug_2 !== exp_flags) report_mismatch("debug_2_o", debug_2, exp_flags);
    if (debug_1 !== 32'd1) report_mismatch("debug_1_o", debug_1, 1);
    run_pass(0);
    check_writes(0);
    if (debug_1 !== 32'd2) report_mismatch("debug_1_o", debug_1, 2);
    pulse_clear();
    if (debug_1 !== 32'h0) report_mismatch("debug_1_o", debug_1, 0);
    if (debug_2 !== 32'h0) report_mismatch("debug_2_o", debug_2, 0);
    if (debug_3 !== 32'h0) report_mismatch("debug_3_o", debug_3, 0);
  endtask

  task automatic test_row_captures();
    logic [31:0] exp_cap;
    tests_run++;
    build_random(22, 2);
    // The first entry of every row feeds lane 2 so each row carries its own lane 2 value
    for (int r = 0; r < 22; r++) begin
      ents[2*r][17:14] = 4'd2;
    end
    compute_model();
    load_entries();
    run_pass(0);
    check_writes(0);
    exp_cap = {4'h0, exp_lane[20][2], 4'h0, exp_lane[10][2]};
    if (debug_3 !== exp_cap) report_mismatch("debug_3_o", debug_3, exp_cap);
  endtask

  task automatic test_region_flag();
    tests_run++;
    pulse_clear();
    if (debug_3 !== 32'h0) report_mismatch("debug_3_o", debug_3, 0);  // Captures of row 10 and 20 are gone
    build_random(2, 3);
    compute_model();
    load_entries();
    run_pass(43320);
    check_writes(43320);
    if (debug_2[OVER_BIT] !== 1'b1) report_mismatch("debug_2_o[8]", debug_2[OVER_BIT], 1);
    pulse_clear();
    run_pass(0);
    check_writes(0);
    if (debug_2[OVER_BIT] !== 1'b0) report_mismatch("debug_2_o[8]", debug_2[OVER_BIT], 0);
  endtask

  task automatic test_wrap_shift();
    tests_run++;
    num_ents = 3;
    ents[0]  = make_entry(1'b0, 4'd5, 2'd2, 12'hfff);
    ents[1]  = make_entry(1'b0, 4'd5, 2'd2, 12'hfff);
    ents[2]  = make_entry(1'b1, 4'd5, 2'd2, 12'hfff);
    compute_model();
    load_entries();
    run_pass(0);
    check_writes(0);
    // Lane 5 sits in the upper half of word 2
    if (wr_data_q.size() < 3) begin
      $display("Error at %0t: lane 5 word was never written", $time);
      errors++;
    end else if (wr_data_q[2][27:16] !== exp_lane[0][5]) begin
      report_mismatch("feat_bram_din_o[27:16]", wr_data_q[2][27:16], exp_lane[0][5]);
    end
  endtask

  initial begin
    rst_n     = 1'b0;
    load_we   = 1'b0;
    load_addr = '0;
    load_data = '0;
    start     = 1'b0;
    nnz       = '0;
    feat_base = '0;
    dbg_clear = 1'b0;
    errors    = 0;
    tests_run = 0;
    rng_state = 32'd66;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    test_reset_state();
    test_single_pass();
    test_flags_counter();
    test_row_captures();
    test_region_flag();
    test_wrap_shift();
    $display("Tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: logic/feat_writer.sv
module feat_writer (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    row_vld_i,
  input  gat_pkg::row_addr_t                      row_i,
  input  gat_pkg::pe_data_t [gat_pkg::NUM_PE-1:0] sppe_i,
  input  gat_pkg::feat_addr_t                     feat_base_i,
  output logic                                    busy_o,
  output logic                                    feat_bram_ena_o,
  output gat_pkg::feat_addr_t                     feat_bram_addra_o,
  output gat_pkg::feat_data_t                     feat_bram_din_o
);

  logic                                    active_q;
  logic [gat_pkg::WORD_IDX_W-1:0]          word_q;
  gat_pkg::feat_addr_t                     row_addr_q;
  gat_pkg::pe_data_t [gat_pkg::NUM_PE-1:0] lanes_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q <= 1'b0;
      word_q   <= '0;
    end else if (row_vld_i) begin
      active_q <= 1'b1;
      word_q   <= '0;
    end else if (active_q) begin
      word_q <= word_q + 1'b1;
      if (word_q == gat_pkg::WORD_IDX_W'(gat_pkg::WORDS_PER_ROW - 1)) begin
        active_q <= 1'b0;
      end
    end
  end

  // Row snapshot and its first feature address
  always_ff @(posedge clk) begin
    if (row_vld_i) begin
      lanes_q    <= sppe_i;
      row_addr_q <= gat_pkg::feat_addr_t'(feat_base_i + row_i * gat_pkg::WORDS_PER_ROW);
    end
  end

  // Word k carries lane 2k+1 in the upper half and lane 2k in the lower half
  always_comb begin
    feat_bram_din_o = '0;
    feat_bram_din_o[gat_pkg::FEAT_HALF_W +: gat_pkg::PE_W] = lanes_q[{word_q, 1'b1}];
    feat_bram_din_o[0 +: gat_pkg::PE_W]                    = lanes_q[{word_q, 1'b0}];
  end

  assign feat_bram_addra_o = row_addr_q + word_q;
  assign feat_bram_ena_o   = active_q;
  assign busy_o            = active_q;

endmodule

// File: logic/gat_top.sv
module gat_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      load_we_i,
  input  gat_pkg::entry_addr_t      load_addr_i,
  input  gat_pkg::entry_t           load_data_i,
  input  logic                      start_i,
  input  gat_pkg::entry_addr_t      nnz_i,
  input  gat_pkg::feat_addr_t       feat_base_i,
  input  logic                      dbg_clear_i,
  output logic                      done_o,
  output logic                      feat_bram_ena_o,
  output gat_pkg::feat_addr_t       feat_bram_addra_o,
  output gat_pkg::feat_data_t       feat_bram_din_o,
  output logic [gat_pkg::DBG_W-1:0] debug_1_o,
  output logic [gat_pkg::DBG_W-1:0] debug_2_o,
  output logic [gat_pkg::DBG_W-1:0] debug_3_o
);

  logic spmm_vld;
  logic spmm_rdy;
  logic dmvm_vld;
  logic dmvm_rdy;
  logic sm_vld;
  logic sm_rdy;
  logic aggr_vld;
  logic aggr_rdy;

  gat_pkg::entry_addr_t                    h_data_bram_addrb;
  gat_pkg::entry_t                         h_data_bram_dout;
  logic                                    row_vld;
  gat_pkg::row_addr_t                      wh_bram_addra;
  gat_pkg::pe_data_t [gat_pkg::NUM_PE-1:0] sppe;
  logic                                    busy;

  h_data_bram u_h_data_bram (
    .clk     (clk),
    .we_i    (load_we_i),
    .addra_i (load_addr_i),
    .dina_i  (load_data_i),
    .addrb_i (h_data_bram_addrb),
    .doutb_o (h_data_bram_dout)
  );

  spmm_engine u_spmm_engine (
    .clk                 (clk),
    .rst_n               (rst_n),
    .spmm_vld_i          (spmm_vld),
    .nnz_i               (nnz_i),
    .h_data_bram_dout_i  (h_data_bram_dout),
    .busy_i              (busy),
    .h_data_bram_addrb_o (h_data_bram_addrb),
    .row_vld_o           (row_vld),
    .wh_bram_addra_o     (wh_bram_addra),
    .sppe_o              (sppe),
    .spmm_rdy_o          (spmm_rdy)
  );

  feat_writer u_feat_writer (
    .clk               (clk),
    .rst_n             (rst_n),
    .row_vld_i         (row_vld),
    .row_i             (wh_bram_addra),
    .sppe_i            (sppe),
    .feat_base_i       (feat_base_i),
    .busy_o            (busy),
    .feat_bram_ena_o   (feat_bram_ena_o),
    .feat_bram_addra_o (feat_bram_addra_o),
    .feat_bram_din_o   (feat_bram_din_o)
  );

  stage_sequencer u_stage_sequencer (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (start_i),
    .spmm_rdy_i (spmm_rdy),
    .dmvm_rdy_i (dmvm_rdy),
    .sm_rdy_i   (sm_rdy),
    .aggr_rdy_i (aggr_rdy),
    .spmm_vld_o (spmm_vld),
    .dmvm_vld_o (dmvm_vld),
    .sm_vld_o   (sm_vld),
    .aggr_vld_o (aggr_vld),
    .done_o     (done_o)
  );

  stage_timer #(.LATENCY(gat_pkg::DMVM_LAT)) u_dmvm_timer (
    .clk   (clk),
    .rst_n (rst_n),
    .vld_i (dmvm_vld),
    .rdy_o (dmvm_rdy)
  );

  stage_timer #(.LATENCY(gat_pkg::SM_LAT)) u_sm_timer (
    .clk   (clk),
    .rst_n (rst_n),
    .vld_i (sm_vld),
    .rdy_o (sm_rdy)
  );

  stage_timer #(.LATENCY(gat_pkg::AGGR_LAT)) u_aggr_timer (
    .clk   (clk),
    .rst_n (rst_n),
    .vld_i (aggr_vld),
    .rdy_o (aggr_rdy)
  );

  debugger u_debugger (
    .clk               (clk),
    .rst_n             (rst_n),
    .clear_i           (dbg_clear_i),
    .spmm_vld_i        (spmm_vld),
    .spmm_rdy_i        (spmm_rdy),
    .dmvm_vld_i        (dmvm_vld),
    .dmvm_rdy_i        (dmvm_rdy),
    .sm_vld_i          (sm_vld),
    .sm_rdy_i          (sm_rdy),
    .aggr_vld_i        (aggr_vld),
    .aggr_rdy_i        (aggr_rdy),
    .row_vld_i         (row_vld),
    .wh_bram_addra_i   (wh_bram_addra),
    .sppe2_i           (sppe[gat_pkg::CAPTURE_LANE]),
    .feat_bram_ena_i   (feat_bram_ena_o),
    .feat_bram_addra_i (feat_bram_addra_o),
    .debug_1_o         (debug_1_o),
    .debug_2_o         (debug_2_o),
    .debug_3_o         (debug_3_o)
  );

endmodule

// File: logic/h_data_bram.sv
module h_data_bram (
  input  logic                 clk,
  input  logic                 we_i,
  input  gat_pkg::entry_addr_t addra_i,
  input  gat_pkg::entry_t      dina_i,
  input  gat_pkg::entry_addr_t addrb_i,
  output gat_pkg::entry_t      doutb_o
);

  gat_pkg::entry_t mem [0:gat_pkg::ENTRY_DEPTH-1];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[addra_i] <= dina_i;
    end
  end

  // Registered read so the entry shows up one cycle after its address
  always_ff @(posedge clk) begin
    doutb_o <= mem[addrb_i];
  end

endmodule

// File: logic/stage_sequencer.sv
module stage_sequencer (
  input  logic clk,
  input  logic rst_n,
  input  logic start_i,
  input  logic spmm_rdy_i,
  input  logic dmvm_rdy_i,
  input  logic sm_rdy_i,
  input  logic aggr_rdy_i,
  output logic spmm_vld_o,
  output logic dmvm_vld_o,
  output logic sm_vld_o,
  output logic aggr_vld_o,
  output logic done_o
);

  gat_pkg::seq_state_t state_q;
  gat_pkg::seq_state_t state_d;

  logic spmm_vld_d;
  logic dmvm_vld_d;
  logic sm_vld_d;
  logic aggr_vld_d;
  logic done_d;

  always_comb begin
    state_d    = state_q;
    spmm_vld_d = 1'b0;
    dmvm_vld_d = 1'b0;
    sm_vld_d   = 1'b0;
    aggr_vld_d = 1'b0;
    done_d     = 1'b0;
    case (state_q)
      gat_pkg::IDLE: begin
        if (start_i) begin
          state_d    = gat_pkg::SPMM_RUN;
          spmm_vld_d = 1'b1;
        end
      end
      gat_pkg::SPMM_RUN: begin
        if (spmm_rdy_i) begin
          state_d    = gat_pkg::DMVM_RUN;
          dmvm_vld_d = 1'b1;
        end
      end
      gat_pkg::DMVM_RUN: begin
        if (dmvm_rdy_i) begin
          state_d  = gat_pkg::SM_RUN;
          sm_vld_d = 1'b1;
        end
      end
      gat_pkg::SM_RUN: begin
        if (sm_rdy_i) begin
          state_d    = gat_pkg::AGGR_RUN;
          aggr_vld_d = 1'b1;
        end
      end
      gat_pkg::AGGR_RUN: begin
        if (aggr_rdy_i) begin
          state_d = gat_pkg::IDLE;
          done_d  = 1'b1;  // Layer pass complete
        end
      end
      default: state_d = gat_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= gat_pkg::IDLE;
      spmm_vld_o <= 1'b0;
      dmvm_vld_o <= 1'b0;
      sm_vld_o   <= 1'b0;
      aggr_vld_o <= 1'b0;
      done_o     <= 1'b0;
    end else begin
      state_q    <= state_d;
      spmm_vld_o <= spmm_vld_d;
      dmvm_vld_o <= dmvm_vld_d;
      sm_vld_o   <= sm_vld_d;
      aggr_vld_o <= aggr_vld_d;
      done_o     <= done_d;
    end
  end

endmodule

// File: logic/stage_timer.sv
module stage_timer #(
  parameter int unsigned LATENCY = 1
) (
  input  logic clk,
  input  logic rst_n,
  input  logic vld_i,
  output logic rdy_o
);

  logic [gat_pkg::TIMER_W-1:0] cnt_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (vld_i) begin
      cnt_q <= gat_pkg::TIMER_W'(LATENCY);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Count of one is reached exactly LATENCY cycles after the load
  assign rdy_o = (cnt_q == gat_pkg::TIMER_W'(1));

endmodule

// File: spmm/spmm_engine.sv
module spmm_engine (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    spmm_vld_i,
  input  gat_pkg::entry_addr_t                    nnz_i,
  input  gat_pkg::entry_t                         h_data_bram_dout_i,
  input  logic                                    busy_i,
  output gat_pkg::entry_addr_t                    h_data_bram_addrb_o,
  output logic                                    row_vld_o,
  output gat_pkg::row_addr_t                      wh_bram_addra_o,
  output gat_pkg::pe_data_t [gat_pkg::NUM_PE-1:0] sppe_o,
  output logic                                    spmm_rdy_o
);

  typedef enum logic [1:0] {
    ENG_IDLE,
    ENG_RUN,
    ENG_DRAIN
  } eng_state_t;

  eng_state_t                              state_q;
  gat_pkg::entry_addr_t                    rd_addr_q;
  gat_pkg::entry_addr_t                    remain_q;
  logic                                    data_vld_q;
  logic                                    row_vld_q;
  logic                                    rdy_q;
  gat_pkg::row_addr_t                      row_q;
  gat_pkg::pe_data_t [gat_pkg::NUM_PE-1:0] lanes_q;
  gat_pkg::pe_data_t [gat_pkg::NUM_PE-1:0] lanes_d;

  logic                            stall;
  logic                            consume;
  logic                            last_entry;
  logic                            ent_row_end;
  logic [gat_pkg::LANE_IDX_W-1:0]  ent_lane;
  logic [gat_pkg::SHIFT_W-1:0]     ent_shift;
  gat_pkg::pe_data_t               ent_value;
  gat_pkg::pe_data_t               ent_term;

  assign ent_row_end = h_data_bram_dout_i[gat_pkg::ENT_ROW_END_BIT];
  assign ent_lane    = h_data_bram_dout_i[gat_pkg::ENT_LANE_LSB +: gat_pkg::LANE_IDX_W];
  assign ent_shift   = h_data_bram_dout_i[gat_pkg::ENT_SHIFT_LSB +: gat_pkg::SHIFT_W];
  assign ent_value   = h_data_bram_dout_i[gat_pkg::ENT_VALUE_LSB +: gat_pkg::PE_W];
  assign ent_term    = ent_value << ent_shift;  // Upper bits fall off so lanes wrap

  // The row on sppe_o must stay put until the writer has taken it
  assign stall      = busy_i | row_vld_q;
  assign consume    = (state_q == ENG_RUN) && data_vld_q && !stall;
  assign last_entry = (remain_q == gat_pkg::entry_addr_t'(1));

  // Holding the address keeps the stalled entry on the read port
  assign h_data_bram_addrb_o = consume ? rd_addr_q + 1'b1 : rd_addr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= ENG_IDLE;
      rd_addr_q  <= '0;
      remain_q   <= '0;
      data_vld_q <= 1'b0;
      row_vld_q  <= 1'b0;
      rdy_q      <= 1'b0;
      row_q      <= '0;
    end else begin
      rdy_q     <= 1'b0;
      row_vld_q <= consume && ent_row_end;
      if (row_vld_q) begin
        row_q <= row_q + 1'b1;
      end
      if (spmm_vld_i) begin
        state_q    <= ENG_RUN;
        rd_addr_q  <= '0;
        remain_q   <= nnz_i;
        data_vld_q <= 1'b0;
        row_q      <= '0;
      end else begin
        case (state_q)
          ENG_RUN: begin
            rd_addr_q  <= h_data_bram_addrb_o;
            data_vld_q <= 1'b1;
            if (consume) begin
              remain_q <= remain_q - 1'b1;
              if (last_entry) state_q <= ENG_DRAIN;
            end
          end
          ENG_DRAIN: begin
            if (!stall) begin  // Last row has been fully written
              rdy_q   <= 1'b1;
              state_q <= ENG_IDLE;
            end
          end
          default: state_q <= ENG_IDLE;
        endcase
      end
    end
  end

  always_comb begin
    lanes_d = lanes_q;
    if (spmm_vld_i || row_vld_q) begin
      lanes_d = '0;
    end else if (consume) begin
      lanes_d[ent_lane] = lanes_q[ent_lane] + ent_term;
    end
  end

  always_ff @(posedge clk) begin
    lanes_q <= lanes_d;
  end

  assign row_vld_o       = row_vld_q;
  assign wh_bram_addra_o = row_q;
  assign sppe_o          = lanes_q;
  assign spmm_rdy_o      = rdy_q;

endmodule

// File: src.f
common/gat_pkg.sv
logic/h_data_bram.sv
spmm/spmm_engine.sv
logic/feat_writer.sv
logic/stage_timer.sv
logic/stage_sequencer.sv
debugger/debugger.sv
logic/gat_top.sv
dv/tb_gat_top.sv
